/* stream_valve_pkg.sv */
/*
 * Stream valve shared definitions.
 * Pipe-mode selection and default widths for the gated stream path.
 */
package stream_valve_pkg;

   // ==============================
   // Pipe placement around the gate
   // ==============================

   // Selects which sides of the valve get a register slice.
   typedef enum logic [1:0] {
      PIPE_BOTH = 2'd0,   // Slice before and after the gate.
      PIPE_IN   = 2'd1,   // Slice on the upstream side only.
      PIPE_OUT  = 2'd2,   // Slice on the downstream side only.
      PIPE_NONE = 2'd3    // Plain wiring, zero latency.
   } pipe_mode_e;

   // ==============================
   // Default widths
   // ==============================

   // Data bus width in bits. Keep is one bit per byte.
   localparam int DATA_W_DEF = 32;

   // Width of the tuser sideband.
   localparam int USER_W_DEF = 1;

   // Packet counter width, wraps at 2**CNT_W.
   localparam int CNT_W = 16;

endpackage

/* axis_pipe_stage.sv */
/*
 * AXI-stream register slice.
 * Main register plus a skid entry, so one beat per cycle with a
 * tready that comes straight from a flop.
 */
`timescale 1ns/1ps
module axis_pipe_stage #(
   parameter int DATA_W = stream_valve_pkg::DATA_W_DEF,
   parameter int USER_W = stream_valve_pkg::USER_W_DEF
) (
   input  logic                aclk,
   input  logic                reset,
   // Upstream side.
   input  logic [DATA_W-1:0]   in_tdata,
   input  logic [DATA_W/8-1:0] in_tkeep,
   input  logic [USER_W-1:0]   in_tuser,
   input  logic                in_tlast,
   input  logic                in_tvalid,
   output logic                in_tready,
   // Downstream side.
   output logic [DATA_W-1:0]   out_tdata,
   output logic [DATA_W/8-1:0] out_tkeep,
   output logic [USER_W-1:0]   out_tuser,
   output logic                out_tlast,
   output logic                out_tvalid,
   input  logic                out_tready
);

   // Skid entry, only filled while the main register is stalled.
   logic                skid_valid;
   logic [DATA_W-1:0]   skid_tdata;
   logic [DATA_W/8-1:0] skid_tkeep;
   logic [USER_W-1:0]   skid_tuser;
   logic                skid_tlast;

   logic in_xfer;     // Beat accepted upstream.
   logic out_xfer;    // Beat taken downstream.
   logic main_load;   // Main register free for a new beat.

   // Two entries held means skid is full. Ready is just its inverse.
   assign in_tready = ~skid_valid;   // Straight from a flop.
   assign in_xfer   = in_tvalid & in_tready;
   assign out_xfer  = out_tvalid & out_tready;
   assign main_load = ~out_tvalid | out_xfer;

   // ==============================
   // Occupancy
   // ==============================
   always_ff @(posedge aclk) begin
      if (reset) begin
         out_tvalid <= 1'b0;
         skid_valid <= 1'b0;
      end else begin
         if (main_load) begin
            out_tvalid <= skid_valid | in_xfer;   // Skid first, keeps order.
            skid_valid <= 1'b0;
         end else if (in_xfer) begin
            skid_valid <= 1'b1;                   // Stalled, park the beat.
         end
      end
   end

   // ==============================
   // Payload
   // ==============================
   always_ff @(posedge aclk) begin
      if (main_load) begin
         if (skid_valid) begin
            out_tdata <= skid_tdata;
            out_tkeep <= skid_tkeep;
            out_tuser <= skid_tuser;
            out_tlast <= skid_tlast;
         end else if (in_xfer) begin
            out_tdata <= in_tdata;
            out_tkeep <= in_tkeep;
            out_tuser <= in_tuser;
            out_tlast <= in_tlast;
         end
      end
      // Skid only captures when main holds a stalled beat.
      if (!main_load && in_xfer) begin
         skid_tdata <= in_tdata;
         skid_tkeep <= in_tkeep;
         skid_tuser <= in_tuser;
         skid_tlast <= in_tlast;
      end
   end

   // A stalled output keeps its beat, payload included, until taken.
   a_out_hold : assert property (@(posedge aclk) disable iff (reset)
      out_tvalid && !out_tready |=>
         out_tvalid && $stable(out_tdata) && $stable(out_tkeep) &&
         $stable(out_tuser) && $stable(out_tlast))
      else $error("axis_pipe_stage: out beat dropped or changed under stall.");

endmodule

/* axis_valve_with_pipe.sv */
/*
 * Stream valve with optional register slices.
 * Gates valid, last and ready between the slices and reports each
 * beat that passes the gate point.
 */
`timescale 1ns/1ps
module axis_valve_with_pipe #(
   parameter int                         DATA_W    = stream_valve_pkg::DATA_W_DEF,
   parameter int                         USER_W    = stream_valve_pkg::USER_W_DEF,
   parameter stream_valve_pkg::pipe_mode_e PIPE_MODE = stream_valve_pkg::PIPE_BOTH
) (
   input  logic                aclk,
   input  logic                reset,
   input  logic                gate_open,   // From valve_control.
   input  logic [DATA_W-1:0]   s_tdata,
   input  logic [DATA_W/8-1:0] s_tkeep,
   input  logic [USER_W-1:0]   s_tuser,
   input  logic                s_tlast,
   input  logic                s_tvalid,
   output logic                s_tready,
   output logic [DATA_W-1:0]   m_tdata,
   output logic [DATA_W/8-1:0] m_tkeep,
   output logic [USER_W-1:0]   m_tuser,
   output logic                m_tlast,
   output logic                m_tvalid,
   input  logic                m_tready,
   output logic                gate_beat,   // Transfer at the gate point.
   output logic                gate_last    // Its tlast.
);
   import stream_valve_pkg::*;

   // Stream after the input slice, upstream of the gate.
   logic [DATA_W-1:0]   post_in_tdata;
   logic [DATA_W/8-1:0] post_in_tkeep;
   logic [USER_W-1:0]   post_in_tuser;
   logic                post_in_tlast, post_in_tvalid, post_in_tready;
   // Stream past the gate, into the output slice.
   logic                pre_out_tlast, pre_out_tvalid, pre_out_tready;

   // ==============================
   // Input side
   // ==============================
   if (PIPE_MODE == PIPE_BOTH || PIPE_MODE == PIPE_IN) begin : g_in_pipe
      axis_pipe_stage #(.DATA_W(DATA_W), .USER_W(USER_W)) in_pipe_i (
         .aclk(aclk), .reset(reset),
         .in_tdata(s_tdata), .in_tkeep(s_tkeep), .in_tuser(s_tuser),
         .in_tlast(s_tlast), .in_tvalid(s_tvalid), .in_tready(s_tready),
         .out_tdata(post_in_tdata), .out_tkeep(post_in_tkeep),
         .out_tuser(post_in_tuser), .out_tlast(post_in_tlast),
         .out_tvalid(post_in_tvalid), .out_tready(post_in_tready));
   end else begin : g_in_direct
      assign post_in_tdata  = s_tdata;
      assign post_in_tkeep  = s_tkeep;
      assign post_in_tuser  = s_tuser;
      assign post_in_tlast  = s_tlast;
      assign post_in_tvalid = s_tvalid;
      assign s_tready       = post_in_tready;
   end

   // ==============================
   // Gate point
   // ==============================
   assign pre_out_tvalid = post_in_tvalid & gate_open;   // Closed, nothing offered.
   assign pre_out_tlast  = post_in_tlast & gate_open;
   assign post_in_tready = pre_out_tready & gate_open;   // Closed, nothing taken.

   assign gate_beat = pre_out_tvalid & pre_out_tready;
   assign gate_last = pre_out_tlast;

   // ==============================
   // Output side
   // ==============================
   if (PIPE_MODE == PIPE_BOTH || PIPE_MODE == PIPE_OUT) begin : g_out_pipe
      axis_pipe_stage #(.DATA_W(DATA_W), .USER_W(USER_W)) out_pipe_i (
         .aclk(aclk), .reset(reset),
         .in_tdata(post_in_tdata), .in_tkeep(post_in_tkeep),
         .in_tuser(post_in_tuser), .in_tlast(pre_out_tlast),
         .in_tvalid(pre_out_tvalid), .in_tready(pre_out_tready),
         .out_tdata(m_tdata), .out_tkeep(m_tkeep), .out_tuser(m_tuser),
         .out_tlast(m_tlast), .out_tvalid(m_tvalid), .out_tready(m_tready));
   end else begin : g_out_direct
      assign m_tdata        = post_in_tdata;
      assign m_tkeep        = post_in_tkeep;
      assign m_tuser        = post_in_tuser;
      assign m_tlast        = pre_out_tlast;
      assign m_tvalid       = pre_out_tvalid;
      assign pre_out_tready = m_tready;
   end

   // A beat waiting at a closed gate stays where it is.
   a_gate_closed : assert property (@(posedge aclk) disable iff (reset)
      post_in_tvalid && !gate_open |=>
         post_in_tvalid && $stable(post_in_tdata) && $stable(post_in_tkeep) &&
         $stable(post_in_tuser) && $stable(post_in_tlast))
      else $error("axis_valve_with_pipe: beat passed a closed gate.");

endmodule

/* valve_control.sv */
/*
 * Valve control.
 * Applies open and close requests only between packets at the gate
 * point, and counts packets leaving the path.
 */
`timescale 1ns/1ps
module valve_control (
   input  logic                              aclk,
   input  logic                              reset,
   input  logic                              open_req,      // One-cycle pulse.
   input  logic                              close_req,     // One-cycle pulse.
   input  logic                              gate_beat,
   input  logic                              gate_last,
   input  logic                              out_beat_last, // Output beat with tlast.
   output logic                              gate_open,
   output logic [stream_valve_pkg::CNT_W-1:0] pkt_count
);

   logic pkt_open;       // Packet started but not finished at the gate.
   logic pkt_open_nxt;   // Same, including this cycle's beat.
   logic close_pend;     // Close waiting for a boundary.
   logic close_want;     // Close asked now or still pending.
   logic close_now;      // Close can be applied this cycle.

   // ==============================
   // Packet tracking at the gate
   // ==============================

   // A first beat without tlast opens a packet, a tlast beat ends it.
   assign pkt_open_nxt = gate_beat ? ~gate_last : pkt_open;

   always_ff @(posedge aclk) begin
      if (reset) begin
         pkt_open <= 1'b0;
      end else begin
         pkt_open <= pkt_open_nxt;
      end
   end

   // ==============================
   // Gate level
   // ==============================

   // Close beats open when both arrive. An open alone cancels a
   // pending close, the gate simply stays open.
   assign close_want = close_req | (close_pend & ~open_req);
   assign close_now  = close_want & ~pkt_open_nxt;   // Boundary reached.

   always_ff @(posedge aclk) begin
      if (reset) begin
         gate_open  <= 1'b0;   // Closed out of reset.
         close_pend <= 1'b0;
      end else begin
         if (close_now) begin
            gate_open <= 1'b0;
         end else if (open_req && !close_req) begin
            gate_open <= 1'b1;
         end
         close_pend <= close_want & pkt_open_nxt;   // Mid-packet, wait for tlast.
      end
   end

   // ==============================
   // Packet counter
   // ==============================
   always_ff @(posedge aclk) begin
      if (reset) begin
         pkt_count <= '0;
      end else if (out_beat_last) begin
         pkt_count <= pkt_count + 1'b1;   // Wraps.
      end
   end

   // The gate drops only on a packet boundary at the gate point.
   a_no_cut : assert property (@(posedge aclk) disable iff (reset)
      $fell(gate_open) |-> !pkt_open)
      else $error("valve_control: gate closed inside a packet.");

endmodule

/* stream_valve_top.sv */
/*
 * Gated stream path top level.
 * Joins the valve with its control block and forms the output
 * end-of-packet strobe for the packet counter.
 */
`timescale 1ns/1ps
module stream_valve_top #(
   parameter int                         DATA_W    = stream_valve_pkg::DATA_W_DEF,
   parameter int                         USER_W    = stream_valve_pkg::USER_W_DEF,
   parameter stream_valve_pkg::pipe_mode_e PIPE_MODE = stream_valve_pkg::PIPE_BOTH
) (
   input  logic                              aclk,
   input  logic                              reset,
   // Upstream stream.
   input  logic [DATA_W-1:0]                 s_tdata,
   input  logic [DATA_W/8-1:0]               s_tkeep,
   input  logic [USER_W-1:0]                 s_tuser,
   input  logic                              s_tlast,
   input  logic                              s_tvalid,
   output logic                              s_tready,
   // Downstream stream.
   output logic [DATA_W-1:0]                 m_tdata,
   output logic [DATA_W/8-1:0]               m_tkeep,
   output logic [USER_W-1:0]                 m_tuser,
   output logic                              m_tlast,
   output logic                              m_tvalid,
   input  logic                              m_tready,
   // Control and status.
   input  logic                              open_req,
   input  logic                              close_req,
   output logic                              gate_open,
   output logic [stream_valve_pkg::CNT_W-1:0] pkt_count
);

   logic gate_beat;       // Gate-point transfer.
   logic gate_last;       // Its tlast.
   logic out_beat_last;   // Last beat leaving the path.

   assign out_beat_last = m_tvalid & m_tready & m_tlast;

   // ==============================
   // Datapath
   // ==============================
   axis_valve_with_pipe #(
      .DATA_W(DATA_W), .USER_W(USER_W), .PIPE_MODE(PIPE_MODE)
   ) valve_i (
      .aclk(aclk), .reset(reset), .gate_open(gate_open),
      .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
      .s_tlast(s_tlast), .s_tvalid(s_tvalid), .s_tready(s_tready),
      .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tuser(m_tuser),
      .m_tlast(m_tlast), .m_tvalid(m_tvalid), .m_tready(m_tready),
      .gate_beat(gate_beat), .gate_last(gate_last));

   // ==============================
   // Control
   // ==============================
   valve_control control_i (
      .aclk(aclk),
      .reset(reset),
      .open_req(open_req),
      .close_req(close_req),
      .gate_beat(gate_beat),
      .gate_last(gate_last),
      .out_beat_last(out_beat_last),
      .gate_open(gate_open),
      .pkt_count(pkt_count));

endmodule

/* tb_stream_valve.sv */
/*
 * Testbench for the gated stream path.
 * Random packets with gaps, output stalls and gate toggling, checked
 * against a queue of the beats accepted upstream.
 */
`timescale 1ns/1ps
module tb_stream_valve;
   import stream_valve_pkg::*;

   localparam int DATA_W   = 32;
   localparam int KEEP_W   = DATA_W / 8;
   localparam int USER_W   = 1;
   localparam int BEAT_W   = DATA_W + KEEP_W + USER_W + 1;   // {data, keep, user, last}.
   localparam int NUM_PKTS = 40;
   localparam int MAX_LEN  = 8;
   localparam int PERIOD   = 40;
   // Longest packets, four cycles per beat, plus slack for gate closures.
   localparam int WATCHDOG_NS = NUM_PKTS * MAX_LEN * 4 * PERIOD + 20000;

   logic              aclk = 1'b0;
   logic              reset;
   logic [DATA_W-1:0] s_tdata, m_tdata;
   logic [KEEP_W-1:0] s_tkeep, m_tkeep;
   logic [USER_W-1:0] s_tuser, m_tuser;
   logic              s_tlast, s_tvalid, s_tready;
   logic              m_tlast, m_tvalid, m_tready;
   logic              open_req, close_req, gate_open;
   logic [CNT_W-1:0]  pkt_count;

   logic [31:0]       lfsr_state = 32'd70322;
   logic [BEAT_W-1:0] sent_q[$];   // Accepted beats, oldest first.
   int                len_q[$];    // Lengths of accepted packets.
   logic              s_taken = 1'b0;      // Handshake seen at last negedge.
   logic              out_in_pkt = 1'b0;   // Output packet in progress.
   int                in_cnt = 0, out_cnt = 0, pkts_sent = 0, out_pkts = 0;
   int                beats_in = 0, beats_out = 0;
   logic              opened_once, stall_en, src_en, gate_ctl_en, src_in_pkt;
   int                pkts_started, src_len, src_idx;

   always #(PERIOD / 2) aclk = ~aclk;

   stream_valve_top #(.DATA_W(DATA_W), .USER_W(USER_W), .PIPE_MODE(PIPE_BOTH))
   stream_valve_top_i (
      .aclk(aclk), .reset(reset),
      .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tuser(s_tuser),
      .s_tlast(s_tlast), .s_tvalid(s_tvalid), .s_tready(s_tready),
      .m_tdata(m_tdata), .m_tkeep(m_tkeep), .m_tuser(m_tuser),
      .m_tlast(m_tlast), .m_tvalid(m_tvalid), .m_tready(m_tready),
      .open_req(open_req), .close_req(close_req),
      .gate_open(gate_open), .pkt_count(pkt_count));

   // ==============================
   // Helpers
   // ==============================

   // 32-bit Fibonacci LFSR, taps 32 22 2 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // One LFSR step per bit taken.
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "Run stopped at %0t.", $time);
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      fail_run($sformatf("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                         $time, sig, exp, act));
   endtask

   // Flops settled, inputs not yet changed.
   task automatic to_sample_point;
      @(posedge aclk);
      #1;
   endtask

   // Next beat upstream, with random gaps between beats.
   task automatic step_source;
      logic [31:0] r;
      if (s_tvalid && s_taken) begin
         s_tvalid = 1'b0;   // Beat went in at this edge.
      end
      if (!s_tvalid && src_en) begin
         if (!src_in_pkt && pkts_started < NUM_PKTS) begin
            r = rand_bits(3);
            src_len = int'(r) + 1;   // 1 to 8 beats.
            src_idx = 0;
            src_in_pkt = 1'b1;
            pkts_started++;
         end
         r = rand_bits(2);
         if (src_in_pkt && r != 32'd0) begin
            r = rand_bits(DATA_W);
            s_tdata = r;
            r = rand_bits(KEEP_W);
            s_tkeep = r[KEEP_W-1:0];
            r = rand_bits(USER_W);
            s_tuser = r[USER_W-1:0];
            s_tlast = (src_idx == src_len - 1);
            s_tvalid = 1'b1;
            src_idx++;
            if (s_tlast) src_in_pkt = 1'b0;
         end
      end
   endtask

   // Inputs change 2 ns after the edge.
   task automatic drive_step;
      logic [31:0] r;
      #1;
      open_req = 1'b0;
      close_req = 1'b0;
      r = rand_bits(2);
      m_tready = stall_en ? (r[1:0] != 2'd0) : 1'b1;   // Stall one cycle in four.
      if (gate_ctl_en) begin
         r = rand_bits(5);
         if (r == 32'd0) begin
            close_req = 1'b1;
         end else if (r == 32'd1) begin
            open_req = 1'b1;    // Both at once, close wins.
            close_req = 1'b1;
         end else if (r < 32'd6 && !gate_open) begin
            open_req = 1'b1;
         end
      end
      step_source();
   endtask

   task automatic cycle;
      to_sample_point();
      drive_step();
   endtask

   // Output beat against the head of the sent queue.
   task automatic check_out_beat;
      logic [BEAT_W-1:0] exp;
      int exp_len;
      if (sent_q.size() == 0) begin
         fail_run("An output beat appeared with no input beat left to match it.");
      end else begin
         exp = sent_q.pop_front();
         assert (m_tdata == exp[BEAT_W-1 -: DATA_W])
            else report_mismatch("m_tdata", exp[BEAT_W-1 -: DATA_W], m_tdata);
         assert (m_tkeep == exp[USER_W+1 +: KEEP_W])
            else report_mismatch("m_tkeep", 32'(exp[USER_W+1 +: KEEP_W]), 32'(m_tkeep));
         assert (m_tuser == exp[1 +: USER_W])
            else report_mismatch("m_tuser", 32'(exp[1 +: USER_W]), 32'(m_tuser));
         assert (m_tlast == exp[0])
            else report_mismatch("m_tlast", 32'(exp[0]), 32'(m_tlast));
         beats_out++;
         out_cnt++;
         if (m_tlast) begin
            exp_len = (len_q.size() == 0) ? 0 : len_q.pop_front();
            assert (out_cnt == exp_len)
               else report_mismatch("output packet length", 32'(exp_len), 32'(out_cnt));
            out_cnt = 0;
            out_pkts++;
            out_in_pkt = 1'b0;
         end else begin
            out_in_pkt = 1'b1;
         end
      end
   endtask

   // ==============================
   // Monitor and scoreboard
   // ==============================

   // Mid-cycle, everything stable. A handshake seen here lands at the next edge.
   always @(negedge aclk) begin
      if (reset) begin
         s_taken = 1'b0;
      end else begin
         s_taken = s_tvalid & s_tready;
         if (s_taken) begin
            sent_q.push_back({s_tdata, s_tkeep, s_tuser, s_tlast});
            beats_in++;
            in_cnt++;
            if (s_tlast) begin
               len_q.push_back(in_cnt);
               in_cnt = 0;
               pkts_sent++;
            end
         end
         if (!opened_once) begin
            assert (!m_tvalid) else report_mismatch("m_tvalid", 32'd0, 32'(m_tvalid));
         end
         if (m_tvalid && m_tready) check_out_beat();
         // Gate shut and output pipe empty, so output sits on a boundary.
         if (!gate_open && !m_tvalid) begin
            assert (!out_in_pkt)
               else fail_run("The gate closed while a packet was only partly through.");
         end
      end
   end

   a_stall_hold : assert property (@(negedge aclk) disable iff (reset)
      m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tkeep) &&
         $stable(m_tuser) && $stable(m_tlast))
      else fail_run("m_tvalid or the m_ payload changed while m_tready was low.");

   a_open_timing : assert property (@(negedge aclk) disable iff (reset)
      open_req && !close_req |=> gate_open)
      else fail_run("gate_open was not high one cycle after open_req.");

   a_rise_cause : assert property (@(negedge aclk) disable iff (reset)
      $rose(gate_open) |-> $past(open_req && !close_req))
      else fail_run("gate_open rose without an open request alone.");

   initial begin
      #(WATCHDOG_NS);
      fail_run("Watchdog timeout, the tests did not finish in time.");
   end

   // ==============================
   // Test sequence
   // ==============================
   initial begin
      reset = 1'b1;
      s_tdata = '0;
      s_tkeep = '0;
      s_tuser = '0;
      s_tlast = 1'b0;
      s_tvalid = 1'b0;
      m_tready = 1'b1;
      open_req = 1'b0;
      close_req = 1'b0;
      opened_once = 1'b0;
      stall_en = 1'b0;
      src_en = 1'b0;
      gate_ctl_en = 1'b0;
      src_in_pkt = 1'b0;
      pkts_started = 0;
      src_len = 0;
      src_idx = 0;
      repeat (3) @(posedge aclk);
      #2;
      reset = 1'b0;

      to_sample_point();   // Reset state.
      assert (m_tvalid == 1'b0) else report_mismatch("m_tvalid", 32'd0, 32'(m_tvalid));
      assert (gate_open == 1'b0) else report_mismatch("gate_open", 32'd0, 32'(gate_open));
      assert (pkt_count == '0) else report_mismatch("pkt_count", 32'd0, 32'(pkt_count));

      // Closed valve. Input slice fills its two entries and stops.
      src_en = 1'b1;
      drive_step();
      repeat (20) cycle();
      to_sample_point();
      assert (sent_q.size() == 2)
         else report_mismatch("accepted beats", 32'd2, 32'(sent_q.size()));
      assert (s_tready == 1'b0) else report_mismatch("s_tready", 32'd0, 32'(s_tready));
      drive_step();
      open_req = 1'b1;
      opened_once = 1'b1;

      // Traffic with stalls and random close and reopen.
      stall_en = 1'b1;
      gate_ctl_en = 1'b1;
      while (pkts_started < NUM_PKTS || src_in_pkt || s_tvalid) begin
         cycle();
      end

      // Reopen and drain everything.
      gate_ctl_en = 1'b0;
      cycle();
      open_req = 1'b1;
      while (sent_q.size() != 0) begin
         cycle();
      end

      close_req = 1'b1;   // Gate idle, drops one cycle later.
      to_sample_point();
      assert (gate_open == 1'b0) else report_mismatch("gate_open", 32'd0, 32'(gate_open));
      assert (pkt_count == CNT_W'(pkts_sent))
         else report_mismatch("pkt_count", 32'(CNT_W'(pkts_sent)), 32'(pkt_count));
      assert (out_pkts == NUM_PKTS)
         else report_mismatch("output packets", 32'(NUM_PKTS), 32'(out_pkts));
      drive_step();
      to_sample_point();

      if (beats_out == beats_in && pkts_sent == NUM_PKTS && len_q.size() == 0) begin
         $display("Simulation completed successfully");
         $finish;
      end else begin
         fail_run("Input and output beat or packet totals do not agree.");
      end
   end

endmodule

/* stream_valve.f */
stream_valve_pkg.sv
axis_pipe_stage.sv
axis_valve_with_pipe.sv
valve_control.sv
stream_valve_top.sv
tb_stream_valve.sv

/* run_sim.sh */
#!/bin/sh
# Builds the stream valve testbench with Verilator and runs it.
# The run counts as passed only when the pass message shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_stream_valve \
   -f stream_valve.f

status=0
output=$(./obj_dir/Vtb_stream_valve 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
   echo "run_sim: PASS"
   exit 0
fi

echo "run_sim: FAIL (exit status $status)"
exit 1
